// File: hdl/pentevo_pkg.sv
package pentevo_pkg;

	// basic bus types
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] addr_t;
	typedef logic [7:0]  page_t;

	// four 16k windows over the cpu address space
	localparam int NUM_WIN = 4;
	typedef logic [1:0] win_t;
	typedef page_t [NUM_WIN-1:0] xt_page_t;

	////////////////////////////////////////////////////////////////////////////
	// port addresses
	////////////////////////////////////////////////////////////////////////////

	// low address byte
	localparam byte_t PORT_FE_LO = 8'hFE;
	localparam byte_t PORT_FB_LO = 8'hFB;
	localparam byte_t PORT_AF_LO = 8'hAF;

	// high address byte of the #xxAF group
	localparam byte_t HI_SYSCONF = 8'h20;
	localparam byte_t HI_MEMCONF = 8'h21;
	// window pages at #10..#13
	localparam byte_t HI_PAGE0   = 8'h10;

	////////////////////////////////////////////////////////////////////////////
	// register fields
	////////////////////////////////////////////////////////////////////////////

	// sysconf
	localparam int SYS_TURBO_LSB   = 0;
	localparam int SYS_AYMOD_LSB   = 3;
	localparam int SYS_BEEPMUX_BIT = 5;

	// memconf, set to map ram into window 0
	localparam int MEM_W0RAM_BIT = 3;

	// #FE write
	localparam int FE_BEEP_BIT = 4;
	localparam int FE_BORDER_W = 3;

endpackage

// File: hdl/zbus_if.sv
`timescale 1ns/1ps

interface zbus_if;

	// synchronized address and write data
	pentevo_pkg::addr_t a;
	pentevo_pkg::byte_t wd;

	// one-cycle strobe at start of io write
	logic iowr_s;

	// levels
	logic iord;
	logic mreq;

	modport src (
		output a, wd, iowr_s, iord, mreq
	);

	modport snk (
		input a, wd, iowr_s, iord, mreq
	);

endinterface

// File: hdl/clock_phases.sv
`timescale 1ns/1ps

module clock_phases (
	input  logic       fclk,
	input  logic       rst,
	input  logic [1:0] ay_mod,
	output logic [3:0] c,
	output logic       f0,
	output logic       f1,
	output logic       ay_clk
);

	logic [4:0] ay_cnt;
	logic [4:0] ay_mask;

	// c0 -> c1 -> c2 -> c3 ring, c0 right after reset
	always_ff @(posedge fclk) begin
		if (rst)
			c <= 4'b0001;
		else
			c <= {c[2:0], c[3]};
	end

	assign f0 = c[0] | c[2];
	assign f1 = c[1] | c[3];

	// half period of 4, 8, 16 or 32 fclk
	always_comb begin
		case (ay_mod)
			2'd0:    ay_mask = 5'b00011;
			2'd1:    ay_mask = 5'b00111;
			2'd2:    ay_mask = 5'b01111;
			default: ay_mask = 5'b11111;
		endcase
	end

	always_ff @(posedge fclk) begin
		if (rst) begin
			ay_cnt <= '0;
			ay_clk <= 1'b0;
		end else begin
			ay_cnt <= ay_cnt + 5'd1;
			if ((ay_cnt & ay_mask) == ay_mask)
				ay_clk <= ~ay_clk;
		end
	end

	phase_onehot: assert property (@(posedge fclk) disable iff (rst) $onehot(c));

endmodule

// File: hdl/zbus_sync.sv
`timescale 1ns/1ps

module zbus_sync #(
	parameter int SYNC_STAGES = 2
) (
	input  logic               fclk,
	input  logic               rst,
	input  logic               iorq_n,
	input  logic               mreq_n,
	input  logic               rd_n,
	input  logic               wr_n,
	input  pentevo_pkg::addr_t a,
	input  pentevo_pkg::byte_t d_in,
	zbus_if.src                bus
);

	// bit positions in the strobe vector
	localparam int S_IORQ = 3;
	localparam int S_MREQ = 2;
	localparam int S_RD   = 1;
	localparam int S_WR   = 0;

	logic [3:0]         strb_q [SYNC_STAGES];
	pentevo_pkg::addr_t a_q    [SYNC_STAGES];
	pentevo_pkg::byte_t d_q    [SYNC_STAGES];

	logic [3:0] strb;
	logic       iowr;
	logic       iowr_d;
	logic       iowr_s;

	// active high strobes through the flop chain
	always_ff @(posedge fclk) begin
		if (rst) begin
			for (int i = 0; i < SYNC_STAGES; i++)
				strb_q[i] <= '0;
		end else begin
			strb_q[0] <= {~iorq_n, ~mreq_n, ~rd_n, ~wr_n};
			for (int i = 1; i < SYNC_STAGES; i++)
				strb_q[i] <= strb_q[i-1];
		end
	end

	// address and data travel alongside
	always_ff @(posedge fclk) begin
		a_q[0] <= a;
		d_q[0] <= d_in;
		for (int i = 1; i < SYNC_STAGES; i++) begin
			a_q[i] <= a_q[i-1];
			d_q[i] <= d_q[i-1];
		end
	end

	assign strb = strb_q[SYNC_STAGES-1];
	assign iowr = strb[S_IORQ] & strb[S_WR];

	// rising edge of iorq & wr
	always_ff @(posedge fclk) begin
		if (rst) begin
			iowr_d <= 1'b0;
			iowr_s <= 1'b0;
		end else begin
			iowr_d <= iowr;
			iowr_s <= iowr & ~iowr_d;
		end
	end

	assign bus.a      = a_q[SYNC_STAGES-1];
	assign bus.wd     = d_q[SYNC_STAGES-1];
	assign bus.iowr_s = iowr_s;
	assign bus.iord   = strb[S_IORQ] & strb[S_RD];
	assign bus.mreq   = strb[S_MREQ];

	iowr_single: assert property (@(posedge fclk) disable iff (rst) iowr_s |=> !iowr_s);

endmodule

// File: hdl/port_regs.sv
`timescale 1ns/1ps

module port_regs (
	input  logic                                  fclk,
	input  logic                                  rst,
	zbus_if.snk                                   bus,
	output pentevo_pkg::xt_page_t                 xt_page,
	output pentevo_pkg::byte_t                    memconf,
	output pentevo_pkg::byte_t                    sysconf,
	output logic [pentevo_pkg::FE_BORDER_W-1:0]   border,
	output logic                                  beeper,
	output pentevo_pkg::byte_t                    covox,
	output pentevo_pkg::byte_t                    d_out,
	output logic                                  d_oe
);

	pentevo_pkg::byte_t lo;
	pentevo_pkg::byte_t hi;
	pentevo_pkg::win_t  pg_win;
	pentevo_pkg::byte_t rd_val;

	logic fe_hit;
	logic fb_hit;
	logic af_hit;
	logic sys_hit;
	logic mem_hit;
	logic pg_hit;

	////////////////////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////////////////////

	assign lo = bus.a[7:0];
	assign hi = bus.a[15:8];

	// #FE and #FB ignore the high byte
	assign fe_hit = (lo == pentevo_pkg::PORT_FE_LO);
	assign fb_hit = (lo == pentevo_pkg::PORT_FB_LO);
	assign af_hit = (lo == pentevo_pkg::PORT_AF_LO);

	assign sys_hit = af_hit && (hi == pentevo_pkg::HI_SYSCONF);
	assign mem_hit = af_hit && (hi == pentevo_pkg::HI_MEMCONF);
	// #10AF..#13AF with the window in the low two bits
	assign pg_hit  = af_hit && (hi[7:2] == pentevo_pkg::HI_PAGE0[7:2]);
	assign pg_win  = hi[1:0];

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk) begin
		if (rst) begin
			xt_page <= '0;
			memconf <= '0;
			sysconf <= '0;
			border  <= '0;
			beeper  <= 1'b0;
			covox   <= '0;
		end else if (bus.iowr_s) begin
			if (fe_hit) begin
				border <= bus.wd[pentevo_pkg::FE_BORDER_W-1:0];
				beeper <= bus.wd[pentevo_pkg::FE_BEEP_BIT];
			end
			if (fb_hit)
				covox <= bus.wd;
			if (sys_hit)
				sysconf <= bus.wd;
			if (mem_hit)
				memconf <= bus.wd;
			if (pg_hit)
				xt_page[pg_win] <= bus.wd;
		end
	end

	// readback of the #xxAF group
	always_comb begin
		rd_val = xt_page[pg_win];
		if (sys_hit)
			rd_val = sysconf;
		else if (mem_hit)
			rd_val = memconf;
	end

	always_ff @(posedge fclk) begin
		d_out <= rd_val;
	end

	always_ff @(posedge fclk) begin
		if (rst)
			d_oe <= 1'b0;
		else
			d_oe <= bus.iord && (sys_hit || mem_hit || pg_hit);
	end

	// no io write strobe while read data is on the bus
	oe_in_read: assert property (@(posedge fclk) disable iff (rst) d_oe |-> !bus.iowr_s);

endmodule

// File: hdl/mem_pager.sv
`timescale 1ns/1ps

module mem_pager (
	input  logic                  fclk,
	input  logic                  rst,
	zbus_if.snk                   bus,
	input  pentevo_pkg::xt_page_t xt_page,
	input  pentevo_pkg::byte_t    memconf,
	output pentevo_pkg::page_t    page,
	output logic                  romnram
);

	pentevo_pkg::win_t win;

	// window from the top two address bits
	assign win = bus.a[15:14];

	// window 0 is rom unless memconf maps ram there
	always_ff @(posedge fclk) begin
		if (rst) begin
			page    <= '0;
			romnram <= 1'b1;
		end else if (bus.mreq) begin
			page    <= xt_page[win];
			romnram <= (win == 2'd0) && !memconf[pentevo_pkg::MEM_W0RAM_BIT];
		end
	end

endmodule

// File: hdl/sound_out.sv
`timescale 1ns/1ps

module sound_out (
	input  logic               fclk,
	input  logic               rst,
	input  logic               f0,
	input  logic               beeper,
	input  pentevo_pkg::byte_t covox,
	input  logic               beep_mux,
	output logic               beep
);

	pentevo_pkg::byte_t acc;
	logic               carry;

	// first-order sigma-delta, one carry pulse per overflow
	always_ff @(posedge fclk) begin
		if (rst) begin
			acc   <= '0;
			carry <= 1'b0;
		end else begin
			carry <= 1'b0;
			if (f0)
				{carry, acc} <= {1'b0, acc} + {1'b0, covox};
		end
	end

	// covox stream or plain beeper bit
	always_ff @(posedge fclk) begin
		if (rst)
			beep <= 1'b0;
		else
			beep <= beep_mux ? carry : beeper;
	end

endmodule

// File: hdl/pentevo_core.sv
`timescale 1ns/1ps

module pentevo_core (
	input  logic                                fclk,
	input  logic                                rst,
	input  logic                                iorq_n,
	input  logic                                mreq_n,
	input  logic                                rd_n,
	input  logic                                wr_n,
	input  pentevo_pkg::addr_t                  a,
	input  pentevo_pkg::byte_t                  d_in,
	output pentevo_pkg::byte_t                  d_out,
	output logic                                d_oe,
	output pentevo_pkg::page_t                  page,
	output logic                                romnram,
	output logic [pentevo_pkg::FE_BORDER_W-1:0] border,
	output logic [1:0]                          turbo,
	output logic                                ay_clk,
	output logic                                beep
);

	logic                  f0;
	logic [1:0]            ay_mod;
	logic                  beeper;
	pentevo_pkg::byte_t    covox;
	pentevo_pkg::byte_t    sysconf;
	pentevo_pkg::byte_t    memconf;
	pentevo_pkg::xt_page_t xt_page;

	zbus_if zbus ();

	assign turbo  = sysconf[pentevo_pkg::SYS_TURBO_LSB +: 2];
	assign ay_mod = sysconf[pentevo_pkg::SYS_AYMOD_LSB +: 2];

	////////////////////////////////////////////////////////////////////////////
	// clocks and z80 bus
	////////////////////////////////////////////////////////////////////////////

	// only f0 and the ay clock are needed here
	clock_phases u_clock (.fclk(fclk), .rst(rst), .ay_mod(ay_mod),
		.c(), .f0(f0), .f1(), .ay_clk(ay_clk));

	zbus_sync #(.SYNC_STAGES(2)) u_sync (.fclk(fclk), .rst(rst),
		.iorq_n(iorq_n), .mreq_n(mreq_n), .rd_n(rd_n), .wr_n(wr_n),
		.a(a), .d_in(d_in), .bus(zbus.src));

	////////////////////////////////////////////////////////////////////////////
	// ports, pager, sound
	////////////////////////////////////////////////////////////////////////////

	port_regs u_ports (.fclk(fclk), .rst(rst), .bus(zbus.snk),
		.xt_page(xt_page), .memconf(memconf), .sysconf(sysconf),
		.border(border), .beeper(beeper), .covox(covox),
		.d_out(d_out), .d_oe(d_oe));

	mem_pager u_pager (.fclk(fclk), .rst(rst), .bus(zbus.snk),
		.xt_page(xt_page), .memconf(memconf), .page(page), .romnram(romnram));

	sound_out u_sound (.fclk(fclk), .rst(rst), .f0(f0), .beeper(beeper),
		.covox(covox), .beep_mux(sysconf[pentevo_pkg::SYS_BEEPMUX_BIT]), .beep(beep));

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic fclk,
	output logic rst
);

	// 20 ns period
	initial begin
		fclk = 1'b0;
		forever #10 fclk = ~fclk;
	end

	// reset for the first 10 cycles
	initial begin
		rst = 1'b1;
		repeat (10) @(posedge fclk);
		rst <= 1'b0;
	end

endmodule

// File: verif/tb_core.sv
`timescale 1ns/1ps

module tb_core;

	localparam int N_IO      = 200;
	localparam int N_PAGER   = 32;
	localparam int N_FE      = 32;
	localparam int N_COVOX   = 4;
	localparam int COVOX_CYC = 2048;

	// bus cycles of all tests at 10 held plus 4 idle cycles each
	localparam int N_TRANS    = 1 + 2 * N_IO + N_IO / 10 + 3 * N_PAGER + 1 + N_FE
		+ 1 + N_COVOX + 4;
	localparam int EXTRA_CYC  = N_COVOX * COVOX_CYC + 4 * 3 * 64;
	localparam int TIMEOUT_NS = (10 + N_TRANS * 14 + EXTRA_CYC + 500) * 20;

	logic               fclk;
	logic               rst;
	logic               iorq_n;
	logic               mreq_n;
	logic               rd_n;
	logic               wr_n;
	pentevo_pkg::addr_t a;
	pentevo_pkg::byte_t d_in;
	pentevo_pkg::byte_t d_out;
	logic               d_oe;
	pentevo_pkg::page_t page;
	logic               romnram;
	logic [2:0]         border;
	logic [1:0]         turbo;
	logic               ay_clk;
	logic               beep;

	// reference model of the port registers
	pentevo_pkg::page_t m_page [4];
	pentevo_pkg::byte_t m_sysconf;
	pentevo_pkg::byte_t m_memconf;
	pentevo_pkg::byte_t m_covox;
	logic [31:0]        lcg_state;
	int                 err_cnt;

	tb_clock clk_gen (.fclk(fclk), .rst(rst));

	pentevo_core uut (.fclk(fclk), .rst(rst), .iorq_n(iorq_n), .mreq_n(mreq_n),
		.rd_n(rd_n), .wr_n(wr_n), .a(a), .d_in(d_in), .d_out(d_out), .d_oe(d_oe),
		.page(page), .romnram(romnram), .border(border), .turbo(turbo),
		.ay_clk(ay_clk), .beep(beep));

	function automatic pentevo_pkg::byte_t rand_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			err_cnt++;
			fail_run($sformatf("ERR %s expected %0h actual %0h", name, exp, act));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// bus cycles
	////////////////////////////////////////////////////////////////////////////

	task automatic io_write(input pentevo_pkg::addr_t addr, input pentevo_pkg::byte_t data);
		@(posedge fclk);
		a      <= addr;
		d_in   <= data;
		iorq_n <= 1'b0;
		wr_n   <= 1'b0;
		repeat (10) @(posedge fclk);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
		repeat (3) @(posedge fclk);
		// model follows the port map
		if (addr[7:0] == 8'hFB)
			m_covox = data;
		if (addr[7:0] == 8'hAF && addr[15:8] == 8'h20)
			m_sysconf = data;
		if (addr[7:0] == 8'hAF && addr[15:8] == 8'h21)
			m_memconf = data;
		if (addr[7:0] == 8'hAF && addr[15:10] == 6'b000100)
			m_page[addr[9:8]] = data;
	endtask

	// io read when io is set, memory read otherwise
	task automatic bus_read(input pentevo_pkg::addr_t addr, input logic io,
		output pentevo_pkg::byte_t rd, output logic oe);
		@(posedge fclk);
		a      <= addr;
		iorq_n <= !io;
		mreq_n <= io;
		rd_n   <= 1'b0;
		repeat (9) @(posedge fclk);
		@(negedge fclk);
		rd = d_out;
		oe = d_oe;
		@(posedge fclk);
		iorq_n <= 1'b1;
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		repeat (3) @(posedge fclk);
	endtask

	task automatic measure_half_period(output int n);
		logic prev;
		// sync to an edge first
		@(negedge fclk);
		prev = ay_clk;
		while (ay_clk == prev)
			@(negedge fclk);
		prev = ay_clk;
		n = 0;
		do begin
			@(negedge fclk);
			n++;
		end while (ay_clk == prev);
	endtask

	initial begin
		#(TIMEOUT_NS);
		fail_run($sformatf("timeout after %0d ns, the DUT stopped responding", TIMEOUT_NS));
	end

	initial begin
		pentevo_pkg::addr_t addr;
		pentevo_pkg::byte_t data;
		pentevo_pkg::byte_t rd;
		logic               oe;
		int                 cnt;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		a = '0;
		d_in = '0;
		lcg_state = 32'd98;
		err_cnt = 0;
		m_page = '{default: '0};
		m_sysconf = '0;
		m_memconf = '0;
		m_covox = '0;
		wait (rst === 1'b0);
		@(negedge fclk);
		check_value("reset border", 0, border);
		check_value("reset turbo", 0, turbo);
		check_value("reset beep", 0, beep);
		check_value("reset d_oe", 0, d_oe);
		bus_read({2'b00, rand_byte(), 6'h15}, 1'b0, rd, oe);
		check_value("reset romnram", 1, romnram);

		// random extended port writes with readback
		for (int i = 0; i < N_IO; i++) begin
			cnt = rand_byte() % 6;
			addr = {(cnt < 4) ? 8'h10 + cnt[7:0] : 8'h20 + cnt[7:0] - 8'd4, 8'hAF};
			io_write(addr, rand_byte());
			bus_read(addr, 1'b1, rd, oe);
			check_value("readback d_oe", 1, oe);
			check_value("readback", (cnt == 4) ? m_sysconf : (cnt == 5) ? m_memconf
				: m_page[cnt], rd);
			if (i % 10 == 0) begin
				bus_read({2'b01, rand_byte(), 6'h2F}, 1'b1, rd, oe);
				check_value("undecoded d_oe", 0, oe);
			end
		end

		// pager against random pages and memconf
		for (int i = 0; i < N_PAGER; i++) begin
			data = rand_byte();
			io_write({6'b000100, data[1:0], 8'hAF}, rand_byte());
			io_write(16'h21AF, rand_byte());
			addr = {rand_byte(), rand_byte()};
			bus_read(addr, 1'b0, rd, oe);
			check_value("pager page", m_page[addr[15:14]], page);
			check_value("pager romnram", addr[15:14] == 2'd0 && !m_memconf[3], romnram);
		end

		// border and beeper with the covox mux off
		io_write(16'h20AF, rand_byte() & 8'hDF);
		for (int i = 0; i < N_FE; i++) begin
			data = rand_byte();
			io_write({rand_byte(), 8'hFE}, data);
			@(negedge fclk);
			check_value("fe border", data[2:0], border);
			check_value("fe beep", data[4], beep);
		end

		////////////////////////////////////////////////////////////////////////////
		// covox density and ay divider
		////////////////////////////////////////////////////////////////////////////

		io_write(16'h20AF, rand_byte() | 8'h20);
		for (int i = 0; i < N_COVOX; i++) begin
			io_write({rand_byte(), 8'hFB}, rand_byte());
			cnt = 0;
			repeat (COVOX_CYC) begin
				@(negedge fclk);
				if (beep)
					cnt++;
			end
			if (cnt > 4 * int'(m_covox) + 4 || cnt < 4 * int'(m_covox) - 4) begin
				err_cnt++;
				fail_run($sformatf("covox beep count %0d is not within 4 of %0d",
					cnt, 4 * int'(m_covox)));
			end
		end

		for (int mode = 0; mode < 4; mode++) begin
			data = rand_byte();
			data[4:3] = mode[1:0];
			io_write(16'h20AF, data);
			@(negedge fclk);
			check_value("turbo", data[1:0], turbo);
			measure_half_period(cnt);
			check_value($sformatf("ay half period mode %0d", mode), 1 << (mode + 2), cnt);
		end

		if (err_cnt == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			fail_run("errors were found during the run");
		end
	end

endmodule

// File: files.f
hdl/pentevo_pkg.sv
hdl/zbus_if.sv
hdl/clock_phases.sv
hdl/zbus_sync.sv
hdl/port_regs.sv
hdl/mem_pager.sv
hdl/sound_out.sv
hdl/pentevo_core.sv
verif/tb_clock.sv
verif/tb_core.sv
